//--- branch_predictor.f
rtl/bp_cfg_pkg.sv
rtl/bp_types_pkg.sv
rtl/bp_update_if.sv
rtl/bp_table.sv
rtl/bp_pht.sv
rtl/bp_btb.sv
rtl/bp_ctrl_regs.sv
rtl/branch_predictor.sv
sim/branch_predictor_assert.sv
sim/branch_predictor_tb.sv

//--- rtl/bp_btb.sv
`timescale 1ns/1ns

// direct mapped branch target buffer
module bp_btb (
    input  logic                        clk,
    input  logic                        rst,
    // prediction side
    input  logic [bp_cfg_pkg::PC_W-1:0] pc,
    output logic                        hit,
    output logic [bp_cfg_pkg::PC_W-1:0] target,
    output logic                        uncond,
    // training side
    bp_update_if.sink                   upd
);

    localparam int IDX_W = bp_cfg_pkg::BTB_IDX_W;
    localparam int PC_W  = bp_cfg_pkg::PC_W;

    logic [IDX_W-1:0]         pred_idx;
    logic [IDX_W-1:0]         upd_idx;
    bp_types_pkg::btb_entry_t pred_entry;
    bp_types_pkg::btb_entry_t old_entry;
    bp_types_pkg::btb_entry_t new_entry;
    logic                     train;
    logic                     upd_we;

    // index from low bits, tag from the rest
    assign pred_idx = pc[IDX_W-1:0];
    assign upd_idx  = upd.pc[IDX_W-1:0];

    // lookup
    assign hit    = pred_entry.valid && (pred_entry.tag == pc[PC_W-1:IDX_W]);
    assign target = pred_entry.target;
    assign uncond = pred_entry.uncond;

    // cond and jump both carry a target worth keeping
    assign train = (upd.kind == bp_types_pkg::UPD_COND) ||
                   (upd.kind == bp_types_pkg::UPD_JUMP);

    always_comb begin
        new_entry.valid  = 1'b1;
        new_entry.tag    = upd.pc[PC_W-1:IDX_W];
        new_entry.target = upd.target;
        new_entry.uncond = (upd.kind == bp_types_pkg::UPD_JUMP);
    end

    // skip rewriting an entry that already holds the same contents
    assign upd_we = train && (old_entry != new_entry);

    bp_table #(
        .entry_t (bp_types_pkg::btb_entry_t),
        .IDX_W   (IDX_W)
    ) btb_table_inst (
        .clk         (clk),
        .rst         (rst),
        .raddr0      (pred_idx),
        .rdata0      (pred_entry),
        .raddr1      (upd_idx),
        .rdata1      (old_entry),
        .we          (upd_we),
        .waddr       (upd_idx),
        .wdata       (new_entry),
        .reset_value (bp_types_pkg::BTB_ENTRY_RESET)
    );

endmodule

//--- rtl/bp_cfg_pkg.sv
package bp_cfg_pkg;

    //////////////////////////////
    // address widths
    //////////////////////////////

    // word pc, byte offset already dropped
    localparam int PC_W = 30;

    // 1024 two-bit counters
    localparam int PHT_IDX_W = 10;

    // 256 target entries, direct mapped
    localparam int BTB_IDX_W = 8;
    // tag is everything above the index
    localparam int BTB_TAG_W = PC_W - BTB_IDX_W;

    //////////////////////////////
    // register block
    //////////////////////////////

    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 32;

    // bit 0 is the prediction enable
    localparam logic [CFG_ADDR_W-1:0] REG_CTRL       = 2'd0;
    // conditional updates seen
    localparam logic [CFG_ADDR_W-1:0] REG_BR_COUNT   = 2'd1;
    // conditional updates where pred != taken
    localparam logic [CFG_ADDR_W-1:0] REG_MISS_COUNT = 2'd2;

endpackage

//--- rtl/bp_ctrl_regs.sv
`timescale 1ns/1ns

// enable bit and branch statistics
module bp_ctrl_regs (
    input  logic                              clk,
    input  logic                              rst,
    // register access
    input  logic                              cfg_we,
    input  logic [bp_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [bp_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output logic [bp_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata,
    // to the prediction logic
    output logic                              enable,
    // training bus, watched for statistics
    bp_update_if.sink                         upd
);

    localparam int DATA_W = bp_cfg_pkg::CFG_DATA_W;

    logic [DATA_W-1:0] br_count;
    logic [DATA_W-1:0] miss_count;
    logic              cond_upd;
    logic              mispred;
    logic              wr_ctrl;
    logic              wr_br;
    logic              wr_miss;

    //////////////////////////////
    // decode
    //////////////////////////////

    assign cond_upd = (upd.kind == bp_types_pkg::UPD_COND);
    assign mispred  = cond_upd && (upd.pred != upd.taken);

    assign wr_ctrl = cfg_we && (cfg_addr == bp_cfg_pkg::REG_CTRL);
    assign wr_br   = cfg_we && (cfg_addr == bp_cfg_pkg::REG_BR_COUNT);
    assign wr_miss = cfg_we && (cfg_addr == bp_cfg_pkg::REG_MISS_COUNT);

    //////////////////////////////
    // registers
    //////////////////////////////

    // enable comes up set
    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b1;
        end else if (wr_ctrl) begin
            enable <= cfg_wdata[0];
        end
    end

    // any write clears a count and beats a same-cycle increment
    always_ff @(posedge clk) begin
        if (rst) begin
            br_count   <= '0;
            miss_count <= '0;
        end else begin
            if (wr_br) begin
                br_count <= '0;
            end else if (cond_upd) begin
                br_count <= br_count + 1'b1;
            end
            if (wr_miss) begin
                miss_count <= '0;
            end else if (mispred) begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    // read mux, unmapped address reads zero
    always_comb begin
        case (cfg_addr)
            bp_cfg_pkg::REG_CTRL:       cfg_rdata = {{(DATA_W-1){1'b0}}, enable};
            bp_cfg_pkg::REG_BR_COUNT:   cfg_rdata = br_count;
            bp_cfg_pkg::REG_MISS_COUNT: cfg_rdata = miss_count;
            default:                    cfg_rdata = '0;
        endcase
    end

endmodule

//--- rtl/bp_pht.sv
`timescale 1ns/1ns

// pattern history table, two-bit counters per word pc
module bp_pht (
    input  logic                        clk,
    input  logic                        rst,
    // prediction side
    input  logic [bp_cfg_pkg::PC_W-1:0] pc,
    output bp_types_pkg::ctr_t          ctr,
    // training side
    bp_update_if.sink                   upd
);

    localparam int IDX_W = bp_cfg_pkg::PHT_IDX_W;

    logic [IDX_W-1:0]   pred_idx;
    logic [IDX_W-1:0]   upd_idx;
    bp_types_pkg::ctr_t cur_ctr;
    bp_types_pkg::ctr_t next_ctr;
    logic               upd_we;

    // low word pc bits index both sides
    assign pred_idx = pc[IDX_W-1:0];
    assign upd_idx  = upd.pc[IDX_W-1:0];

    // only conditional branches train the counters
    assign upd_we = (upd.kind == bp_types_pkg::UPD_COND);

    // port 0 predicts, port 1 feeds the update rule
    bp_table #(
        .entry_t (bp_types_pkg::ctr_t),
        .IDX_W   (IDX_W)
    ) pht_table_inst (
        .clk         (clk),
        .rst         (rst),
        .raddr0      (pred_idx),
        .rdata0      (ctr),
        .raddr1      (upd_idx),
        .rdata1      (cur_ctr),
        .we          (upd_we),
        .waddr       (upd_idx),
        .wdata       (next_ctr),
        .reset_value (bp_types_pkg::CTR_RESET)
    );

    //////////////////////////////
    // saturating step
    //////////////////////////////

    // taken moves toward ST, not taken toward SNT
    always_comb begin
        case (cur_ctr)
            bp_types_pkg::CTR_SNT:
                next_ctr = upd.taken ? bp_types_pkg::CTR_WNT : bp_types_pkg::CTR_SNT;
            bp_types_pkg::CTR_WNT:
                next_ctr = upd.taken ? bp_types_pkg::CTR_WT : bp_types_pkg::CTR_SNT;
            bp_types_pkg::CTR_WT:
                next_ctr = upd.taken ? bp_types_pkg::CTR_ST : bp_types_pkg::CTR_WNT;
            bp_types_pkg::CTR_ST:
                next_ctr = upd.taken ? bp_types_pkg::CTR_ST : bp_types_pkg::CTR_WT;
            // x on the read, keep it
            default:
                next_ctr = cur_ctr;
        endcase
    end

endmodule

//--- rtl/bp_table.sv
`timescale 1ns/1ns

// flop array, two async read ports, one write port
module bp_table #(
    parameter type entry_t = logic [1:0],
    parameter int  IDX_W   = 10
) (
    input  logic             clk,
    input  logic             rst,
    // read port 0
    input  logic [IDX_W-1:0] raddr0,
    output entry_t           rdata0,
    // read port 1
    input  logic [IDX_W-1:0] raddr1,
    output entry_t           rdata1,
    // write port
    input  logic             we,
    input  logic [IDX_W-1:0] waddr,
    input  entry_t           wdata,
    // value loaded into every entry on rst
    input  entry_t           reset_value
);

    localparam int DEPTH = 1 << IDX_W;

    entry_t mem [DEPTH];

    // reads see the old value during a write cycle
    assign rdata0 = mem[raddr0];
    assign rdata1 = mem[raddr1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= reset_value;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

//--- rtl/bp_types_pkg.sv
package bp_types_pkg;

    //////////////////////////////
    // direction counter
    //////////////////////////////

    // two-bit saturating, msb is the taken guess
    typedef enum logic [1:0] {
        CTR_SNT = 2'b00,
        CTR_WNT = 2'b01,
        CTR_WT  = 2'b10,
        CTR_ST  = 2'b11
    } ctr_t;

    // every counter starts weakly not taken
    localparam ctr_t CTR_RESET = CTR_WNT;

    //////////////////////////////
    // update kinds from execute
    //////////////////////////////

    // rsvd trains nothing, same as none
    typedef enum logic [1:0] {
        UPD_NONE = 2'b00,
        UPD_COND = 2'b01,
        UPD_JUMP = 2'b10,
        UPD_RSVD = 2'b11
    } upd_kind_t;

    // target buffer entry, 54 bits
    typedef struct packed {
        logic                             valid;
        logic [bp_cfg_pkg::BTB_TAG_W-1:0] tag;
        logic [bp_cfg_pkg::PC_W-1:0]      target;
        logic                             uncond;
    } btb_entry_t;

    // invalid, all fields zero
    localparam btb_entry_t BTB_ENTRY_RESET = '0;

endpackage

//--- rtl/bp_update_if.sv
`timescale 1ns/1ns

// training bus, one strobe per cycle from execute
interface bp_update_if;

    // none / cond / jump
    bp_types_pkg::upd_kind_t         kind;
    // pc of the resolved instruction
    logic [bp_cfg_pkg::PC_W-1:0]     pc;
    // actual outcome
    logic                            taken;
    // resolved target
    logic [bp_cfg_pkg::PC_W-1:0]     target;
    // what fetch guessed for it
    logic                            pred;

    // top level drives the bus
    modport src (
        output kind,
        output pc,
        output taken,
        output target,
        output pred
    );

    // tables and register block listen
    modport sink (
        input kind,
        input pc,
        input taken,
        input target,
        input pred
    );

endinterface

//--- rtl/branch_predictor.sv
`timescale 1ns/1ns

// fetch-stage direction and target predictor
module branch_predictor (
    input  logic                              clk,
    input  logic                              rst,
    // prediction, same cycle as pc
    input  logic [bp_cfg_pkg::PC_W-1:0]       pc,
    output logic                              pred_taken,
    output logic                              pred_hit,
    output logic [bp_cfg_pkg::PC_W-1:0]       pred_target,
    // training from execute
    input  bp_types_pkg::upd_kind_t           update_kind,
    input  logic [bp_cfg_pkg::PC_W-1:0]       update_pc,
    input  logic                              update_taken,
    input  logic [bp_cfg_pkg::PC_W-1:0]       update_target,
    input  logic                              update_pred,
    // register access
    input  logic                              cfg_we,
    input  logic [bp_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [bp_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
    output logic [bp_cfg_pkg::CFG_DATA_W-1:0] cfg_rdata
);

    bp_types_pkg::ctr_t          ctr;
    logic                        btb_hit;
    logic [bp_cfg_pkg::PC_W-1:0] btb_target;
    logic                        btb_uncond;
    logic                        enable;

    // pack the update strobe onto the bus
    bp_update_if upd_bus ();

    assign upd_bus.kind   = update_kind;
    assign upd_bus.pc     = update_pc;
    assign upd_bus.taken  = update_taken;
    assign upd_bus.target = update_target;
    assign upd_bus.pred   = update_pred;

    bp_pht pht_inst (
        .clk (clk),
        .rst (rst),
        .pc  (pc),
        .ctr (ctr),
        .upd (upd_bus.sink)
    );

    bp_btb btb_inst (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .hit    (btb_hit),
        .target (btb_target),
        .uncond (btb_uncond),
        .upd    (upd_bus.sink)
    );

    bp_ctrl_regs ctrl_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .enable    (enable),
        .upd       (upd_bus.sink)
    );

    //////////////////////////////
    // combine
    //////////////////////////////

    // no target known, no prediction
    assign pred_hit    = enable && btb_hit;
    // jumps always taken, cond follows counter msb
    assign pred_taken  = pred_hit && (btb_uncond || ctr[1]);
    assign pred_target = btb_target;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f branch_predictor.f --top-module branch_predictor_tb \
    -Mdir obj_dir -o branch_predictor_tb

./obj_dir/branch_predictor_tb | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1

//--- sim/branch_predictor_assert.sv
`timescale 1ns/1ns

// output checks bound into the predictor top level
module branch_predictor_assert (
    input logic                              clk,
    input logic                              rst,
    input logic [bp_cfg_pkg::PC_W-1:0]       pc,
    input logic                              pred_taken,
    input logic                              pred_hit,
    input logic [bp_cfg_pkg::PC_W-1:0]       pred_target,
    input logic                              enable,
    input bp_types_pkg::upd_kind_t           update_kind,
    input logic [bp_cfg_pkg::PC_W-1:0]       update_pc,
    input logic [bp_cfg_pkg::PC_W-1:0]       update_target,
    input logic                              cfg_we,
    input logic [bp_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input logic [bp_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata
);

    // jump trained last cycle comes back as a taken hit with its target
    jump_predicts_taken: assert property (@(posedge clk) disable iff (rst)
        ($past(update_kind) == bp_types_pkg::UPD_JUMP && pc == $past(update_pc) && enable)
        |-> (pred_hit && pred_taken && pred_target == $past(update_target)))
        else $error("trained jump not predicted taken with its target");

    // clearing the enable bit silences the next prediction
    disable_clears_hit: assert property (@(posedge clk) disable iff (rst)
        (cfg_we && cfg_addr == bp_cfg_pkg::REG_CTRL && !cfg_wdata[0]) |=> !pred_hit)
        else $error("pred_hit high after enable was cleared");

    // execute always drives a defined kind
    kind_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(update_kind))
        else $error("update_kind unknown after reset");

endmodule

//--- sim/branch_predictor_tb.sv
`timescale 1ns/1ns

module branch_predictor_tb;

    localparam int PC_W   = bp_cfg_pkg::PC_W;
    localparam int DATA_W = bp_cfg_pkg::CFG_DATA_W;
    localparam int PHT_N  = 1 << bp_cfg_pkg::PHT_IDX_W;
    localparam int BTB_N  = 1 << bp_cfg_pkg::BTB_IDX_W;
    localparam int N_RAND = 2000;
    localparam int N_EN   = 200;
    // reset and pht sweep and random phases with slack for directed steps
    localparam int TOTAL_CYCLES = 16 + PHT_N + N_RAND + 2 * N_EN + 64;

    logic                              clk;
    logic                              rst;
    logic [PC_W-1:0]                   pc;
    logic                              pred_taken;
    logic                              pred_hit;
    logic [PC_W-1:0]                   pred_target;
    bp_types_pkg::upd_kind_t           update_kind;
    logic [PC_W-1:0]                   update_pc;
    logic                              update_taken;
    logic [PC_W-1:0]                   update_target;
    logic                              update_pred;
    logic                              cfg_we;
    logic [bp_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr;
    logic [DATA_W-1:0]                 cfg_wdata;
    logic [DATA_W-1:0]                 cfg_rdata;

    // reference model state
    bp_types_pkg::ctr_t       m_ctr [PHT_N];
    bp_types_pkg::btb_entry_t m_btb [BTB_N];
    logic                     m_enable;
    logic [DATA_W-1:0]        m_br;
    logic [DATA_W-1:0]        m_miss;

    logic [31:0] rng;
    int          err_count;
    int          err_mark;
    int          check_count;
    int          test_count;

    branch_predictor branch_predictor_inst (.*);

    bind branch_predictor branch_predictor_assert assert_inst (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .pred_taken    (pred_taken),
        .pred_hit      (pred_hit),
        .pred_target   (pred_target),
        .enable        (enable),
        .update_kind   (update_kind),
        .update_pc     (update_pc),
        .update_target (update_target),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata)
    );

    always #5 clk = ~clk;

    // run limit scaled to the test lengths
    initial begin
        #(TOTAL_CYCLES * 10 + 500);
        $display("watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    //////////////////////////////
    // random source
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] draw();
        rng = xorshift(rng);
        return rng;
    endfunction

    // 4 btb slots by 4 tags where tags 0 and 4 share a pht index
    function automatic logic [PC_W-1:0] pool_pc(input logic [31:0] r);
        logic [bp_cfg_pkg::BTB_TAG_W-1:0] tag;
        tag = r[3] ? (r[2] ? 22'h2a5 : 22'h4) : {21'h0, r[2]};
        return {tag, 6'h10, r[1:0]};
    endfunction

    //////////////////////////////
    // model
    //////////////////////////////

    task automatic model_update(input bp_types_pkg::upd_kind_t k, input logic [PC_W-1:0] upc,
                                input logic t, input logic [PC_W-1:0] tgt, input logic pr);
        int pi;
        int bi;
        pi = int'(upc[bp_cfg_pkg::PHT_IDX_W-1:0]);
        bi = int'(upc[bp_cfg_pkg::BTB_IDX_W-1:0]);
        if (k == bp_types_pkg::UPD_COND) begin
            m_br = m_br + 1;
            if (pr != t) m_miss = m_miss + 1;
            // saturate at both ends
            if (t && m_ctr[pi] != bp_types_pkg::CTR_ST)
                m_ctr[pi] = bp_types_pkg::ctr_t'(m_ctr[pi] + 2'd1);
            else if (!t && m_ctr[pi] != bp_types_pkg::CTR_SNT)
                m_ctr[pi] = bp_types_pkg::ctr_t'(m_ctr[pi] - 2'd1);
        end
        if (k == bp_types_pkg::UPD_COND || k == bp_types_pkg::UPD_JUMP) begin
            m_btb[bi].valid  = 1'b1;
            m_btb[bi].tag    = upc[PC_W-1:bp_cfg_pkg::BTB_IDX_W];
            m_btb[bi].target = tgt;
            m_btb[bi].uncond = (k == bp_types_pkg::UPD_JUMP);
        end
    endtask

    function automatic logic [DATA_W-1:0] model_reg(input logic [1:0] addr);
        case (addr)
            bp_cfg_pkg::REG_CTRL:       return {{(DATA_W-1){1'b0}}, m_enable};
            bp_cfg_pkg::REG_BR_COUNT:   return m_br;
            bp_cfg_pkg::REG_MISS_COUNT: return m_miss;
            default:                    return '0;
        endcase
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic report_error(input string msg);
        err_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic compare_dir(input bp_types_pkg::ctr_t exp_ctr, input logic exp_hit,
                               input logic exp_taken);
        check_count++;
        if (branch_predictor_inst.pht_inst.ctr !== exp_ctr || pred_hit !== exp_hit ||
            pred_taken !== exp_taken)
            report_error($sformatf("pc %h ctr/hit/taken %b/%b/%b, expected %b/%b/%b", pc,
                branch_predictor_inst.pht_inst.ctr, pred_hit, pred_taken,
                exp_ctr, exp_hit, exp_taken));
    endtask

    task automatic compare_target(input logic [PC_W-1:0] exp_target);
        check_count++;
        if (pred_target !== exp_target)
            report_error($sformatf("pc %h target %h, expected %h", pc, pred_target, exp_target));
    endtask

    task automatic compare_reg(input logic [DATA_W-1:0] exp_data);
        check_count++;
        if (cfg_rdata !== exp_data)
            report_error($sformatf("reg %0d read %h, expected %h", cfg_addr, cfg_rdata, exp_data));
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // drive at the edge and check mid cycle before the model takes the edge
    task automatic cycle(input logic [PC_W-1:0] p, input bp_types_pkg::upd_kind_t k,
                         input logic [PC_W-1:0] upc, input logic t,
                         input logic [PC_W-1:0] tgt, input logic pr);
        bp_types_pkg::btb_entry_t e;
        logic                     hit;
        @(posedge clk);
        pc            <= p;
        update_kind   <= k;
        update_pc     <= upc;
        update_taken  <= t;
        update_target <= tgt;
        update_pred   <= pr;
        cfg_we        <= 1'b0;
        @(negedge clk);
        e   = m_btb[p[bp_cfg_pkg::BTB_IDX_W-1:0]];
        hit = m_enable && e.valid && (e.tag == p[PC_W-1:bp_cfg_pkg::BTB_IDX_W]);
        compare_dir(m_ctr[p[bp_cfg_pkg::PHT_IDX_W-1:0]], hit,
                    hit && (e.uncond || m_ctr[p[bp_cfg_pkg::PHT_IDX_W-1:0]][1]));
        compare_target(e.target);
        model_update(k, upc, t, tgt, pr);
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        logic [31:0] t;
        r = draw();
        t = draw();
        cycle(pool_pc(r), bp_types_pkg::upd_kind_t'(r[5:4]), pool_pc(r >> 8), r[6],
              t[PC_W-1:0], r[7]);
    endtask

    // one register access with read data checked against the model
    task automatic cfg_access(input logic we, input logic [1:0] addr,
                              input logic [DATA_W-1:0] wdata);
        @(posedge clk);
        update_kind <= bp_types_pkg::UPD_NONE;
        cfg_we      <= we;
        cfg_addr    <= addr;
        cfg_wdata   <= wdata;
        @(negedge clk);
        if (!we) compare_reg(model_reg(addr));
        else if (addr == bp_cfg_pkg::REG_CTRL) m_enable = wdata[0];
        else if (addr == bp_cfg_pkg::REG_BR_COUNT) m_br = '0;
        else if (addr == bp_cfg_pkg::REG_MISS_COUNT) m_miss = '0;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, err_count - err_mark);
        err_mark = err_count;
    endtask

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        rst = 1'b1;
        pc = '0;
        update_kind = bp_types_pkg::UPD_NONE;
        update_pc = '0;
        update_taken = 1'b0;
        update_target = '0;
        update_pred = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        rng = 32'h408a;
        err_count = 0;
        err_mark = 0;
        check_count = 0;
        test_count = 0;
        for (int i = 0; i < PHT_N; i++) m_ctr[i] = bp_types_pkg::CTR_WNT;
        for (int i = 0; i < BTB_N; i++) m_btb[i] = '0;
        m_enable = 1'b1;
        m_br = '0;
        m_miss = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // every pht index with random upper bits
        for (int i = 0; i < PHT_N; i++) begin
            r = draw();
            cycle({r[19:0], i[9:0]}, bp_types_pkg::UPD_NONE, '0, 1'b0, '0, 1'b0);
        end
        cfg_access(1'b0, bp_cfg_pkg::REG_CTRL, '0);
        cfg_access(1'b0, bp_cfg_pkg::REG_BR_COUNT, '0);
        cfg_access(1'b0, bp_cfg_pkg::REG_MISS_COUNT, '0);
        end_test("reset state");

        // climb to strongly taken and back down
        repeat (4) cycle(30'h12345, bp_types_pkg::UPD_COND, 30'h12345, 1'b1, 30'h777, 1'b0);
        repeat (3) cycle(30'h12345, bp_types_pkg::UPD_COND, 30'h12345, 1'b0, 30'h777, 1'b1);
        cycle(30'h12345, bp_types_pkg::UPD_NONE, '0, 1'b0, '0, 1'b0);
        end_test("counter saturation");

        // jump trains and an alias misses while none and rsvd leave the entry alone
        cycle(30'h20055, bp_types_pkg::UPD_JUMP, 30'h20055, 1'b1, 30'h3abcd, 1'b0);
        cycle(30'h20055, bp_types_pkg::UPD_NONE, 30'h20055, 1'b1, 30'h11111, 1'b0);
        cycle(30'h20155, bp_types_pkg::UPD_RSVD, 30'h20055, 1'b1, 30'h22222, 1'b0);
        cycle(30'h20055, bp_types_pkg::UPD_NONE, '0, 1'b0, '0, 1'b0);
        end_test("target buffer");

        repeat (N_RAND) random_cycle();
        end_test("random updates");

        // counts after the random phase and cleared by writes
        cfg_access(1'b0, bp_cfg_pkg::REG_BR_COUNT, '0);
        cfg_access(1'b0, bp_cfg_pkg::REG_MISS_COUNT, '0);
        cfg_access(1'b1, bp_cfg_pkg::REG_BR_COUNT, 32'hffff);
        cfg_access(1'b0, bp_cfg_pkg::REG_BR_COUNT, '0);
        cfg_access(1'b1, bp_cfg_pkg::REG_MISS_COUNT, '0);
        cfg_access(1'b0, bp_cfg_pkg::REG_MISS_COUNT, '0);
        end_test("statistics");

        // disabled while training goes on
        cfg_access(1'b1, bp_cfg_pkg::REG_CTRL, '0);
        cfg_access(1'b0, bp_cfg_pkg::REG_CTRL, '0);
        repeat (N_EN) random_cycle();
        cfg_access(1'b1, bp_cfg_pkg::REG_CTRL, 32'h1);
        cfg_access(1'b0, bp_cfg_pkg::REG_CTRL, '0);
        repeat (N_EN) random_cycle();
        end_test("enable");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
